// File: Makefile
# Verilator build and run for the scope acquisition front end

VERILATOR ?= verilator
TOP       ?= tb_scope_top
FILELIST  ?= scope_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F -- '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/acq_trigger.sv
/*
  acquisition trigger controller
  arms on request, fires on the selected channel edge, freezes both
  channel samples together and counts out the post-trigger window
*/
`default_nettype none

module acq_trigger (
  input  wire logic                      adc_clk,
  input  wire logic                      top_rst,
  // channel results
  adc_chan_if.dst                        ch0,
  adc_chan_if.dst                        ch1,
  // control
  input  wire scope_pkg::trig_src_t      trig_src_i,
  input  wire logic                      arm_i,
  input  wire logic [scope_pkg::cnt_dw-1:0] post_cnt_i,
  // status and snapshot
  output logic                           trig_o,
  output scope_pkg::sample_t             trig_dat0_o,
  output scope_pkg::sample_t             trig_dat1_o,
  output logic                           busy_o,
  output logic                           done_o
);

  scope_pkg::acq_state_t        state_r;
  scope_pkg::trig_src_t         src_r;
  logic [scope_pkg::cnt_dw-1:0] cnt_r;
  scope_pkg::sample_t           dat0_r;
  scope_pkg::sample_t           dat1_r;
  logic                         trig_r;
  logic                         done_r;
  logic                         hit;

  ////////////////////////////////////////
  // source select
  ////////////////////////////////////////

  // source latched at arm, none never fires
  always_comb begin
    case (src_r)
      scope_pkg::trg_ch0_pos: hit = ch0.pos_edge;
      scope_pkg::trg_ch0_neg: hit = ch0.neg_edge;
      scope_pkg::trg_ch1_pos: hit = ch1.pos_edge;
      scope_pkg::trg_ch1_neg: hit = ch1.neg_edge;
      default:                hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_r <= scope_pkg::st_idle;
      src_r   <= scope_pkg::trg_none;
      cnt_r   <= '0;
      dat0_r  <= '0;
      dat1_r  <= '0;
      trig_r  <= 1'b0;
      done_r  <= 1'b0;
    end else begin
      // pulses by default
      trig_r <= 1'b0;
      done_r <= 1'b0;
      case (state_r)
        scope_pkg::st_idle: begin
          if (arm_i) begin
            src_r   <= trig_src_i;
            state_r <= scope_pkg::st_armed;
          end
        end
        scope_pkg::st_armed: begin
          if (hit) begin
            // both channels frozen in the same cycle
            dat0_r  <= ch0.sample;
            dat1_r  <= ch1.sample;
            cnt_r   <= post_cnt_i;
            trig_r  <= 1'b1;
            state_r <= scope_pkg::st_post;
          end
        end
        scope_pkg::st_post: begin
          // zero and one both end right after the trigger
          if (cnt_r <= scope_pkg::cnt_dw'(1)) begin
            cnt_r   <= '0;
            done_r  <= 1'b1;
            state_r <= scope_pkg::st_idle;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        default: begin
          state_r <= scope_pkg::st_idle;
        end
      endcase
    end
  end

  // outputs
  assign trig_o      = trig_r;
  assign done_o      = done_r;
  assign trig_dat0_o = dat0_r;
  assign trig_dat1_o = dat1_r;
  assign busy_o      = (state_r != scope_pkg::st_idle);

endmodule : acq_trigger

`default_nettype wire

// File: hw/adc_chan_if.sv
/*
  ADC channel bus
  one calibrated sample per cycle plus the comparator level and its
  edge pulses, no handshake, valid on every cycle after reset
*/
`default_nettype none

interface adc_chan_if;

  // calibrated sample
  scope_pkg::sample_t sample;
  // high while above the threshold band
  logic               above;
  // single-cycle pulses on level changes
  logic               pos_edge;
  logic               neg_edge;

  // channel side
  modport src (
    output sample,
    output above,
    output pos_edge,
    output neg_edge
  );

  // consumer side
  modport dst (
    input  sample,
    input  above,
    input  pos_edge,
    input  neg_edge
  );

endinterface : adc_chan_if

`default_nettype wire

// File: hw/adc_channel.sv
/*
  ADC channel front end
  registers the converter word, turns the negative-slope coding into
  two's complement, adds a saturating offset and runs a hysteresis
  comparator with registered edge pulses
*/
`default_nettype none

module adc_channel (
  input  wire logic                adc_clk,
  input  wire logic                top_rst,
  // converter word from the pins
  input  wire scope_pkg::raw_t     raw_i,
  // calibration and comparator settings
  input  wire scope_pkg::sample_t  offset_i,
  input  wire scope_pkg::sample_t  level_i,
  input  wire scope_pkg::sample_t  hyst_i,
  // channel results
  adc_chan_if.src                  chan
);

  ////////////////////////////////////////
  // input register
  ////////////////////////////////////////

  scope_pkg::raw_t raw_r;

  // meant to land in the IO block flops
  always_ff @(posedge adc_clk) begin
    raw_r <= raw_i;
  end

  ////////////////////////////////////////
  // sign conversion and offset
  ////////////////////////////////////////

  scope_pkg::sample_t     conv;
  scope_pkg::sample_ext_t sum;
  scope_pkg::sample_t     sat;
  scope_pkg::sample_t     sample_r;

  // negative slope, keep sign and flip the rest
  assign conv = {raw_r[scope_pkg::adc_dw-1], ~raw_r[scope_pkg::adc_dw-2:0]};

  // widened add, guard bit catches the overflow
  assign sum = scope_pkg::sample_ext_t'(conv) + scope_pkg::sample_ext_t'(offset_i);

  // clamp to the sample range
  always_comb begin
    if (sum > scope_pkg::sample_ext_t'(scope_pkg::sample_max)) begin
      sat = scope_pkg::sample_max;
    end else if (sum < scope_pkg::sample_ext_t'(scope_pkg::sample_min)) begin
      sat = scope_pkg::sample_min;
    end else begin
      sat = sum[scope_pkg::adc_dw-1:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sample_r <= '0;
    end else begin
      sample_r <= sat;
    end
  end

  ////////////////////////////////////////
  // hysteresis comparator
  ////////////////////////////////////////

  scope_pkg::sample_t     hyst_pos;
  scope_pkg::sample_ext_t sample_ext;
  scope_pkg::sample_ext_t band_hi;
  scope_pkg::sample_ext_t band_lo;
  logic                   above_r;
  logic                   above_nxt;
  logic                   pos_r;
  logic                   neg_r;

  // negative hysteresis folds to zero width
  assign hyst_pos = hyst_i[scope_pkg::adc_dw-1] ? '0 : hyst_i;

  // band limits at full width
  assign sample_ext = scope_pkg::sample_ext_t'(sample_r);
  assign band_hi    = scope_pkg::sample_ext_t'(level_i) + scope_pkg::sample_ext_t'(hyst_pos);
  assign band_lo    = scope_pkg::sample_ext_t'(level_i) - scope_pkg::sample_ext_t'(hyst_pos);

  // set above the band, clear below, hold inside
  always_comb begin
    if (sample_ext > band_hi) begin
      above_nxt = 1'b1;
    end else if (sample_ext < band_lo) begin
      above_nxt = 1'b0;
    end else begin
      above_nxt = above_r;
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      above_r <= 1'b0;
      pos_r   <= 1'b0;
      neg_r   <= 1'b0;
    end else begin
      above_r <= above_nxt;
      // pulses line up with the new level
      pos_r   <= above_nxt & ~above_r;
      neg_r   <= ~above_nxt & above_r;
    end
  end

  // drive the channel bus
  assign chan.sample   = sample_r;
  assign chan.above    = above_r;
  assign chan.pos_edge = pos_r;
  assign chan.neg_edge = neg_r;

endmodule : adc_channel

`default_nettype wire

// File: hw/scope_pkg.sv
/*
  scope acquisition package
  sample widths and types, saturation limits, trigger source and
  acquisition state encodings shared by the channel and trigger blocks
*/
`default_nettype none

package scope_pkg;

  // ADC sample width, 14-bit converters sit in the upper bits
  localparam int unsigned adc_dw = 16;
  // one guard bit so offset and band sums cannot wrap
  localparam int unsigned ext_dw = adc_dw + 1;
  // post-trigger window counter width
  localparam int unsigned cnt_dw = 16;

  // converter word as it comes off the pins
  typedef logic        [adc_dw-1:0] raw_t;
  // calibrated two's complement sample
  typedef logic signed [adc_dw-1:0] sample_t;
  // widened sample for sums and band limits
  typedef logic signed [ext_dw-1:0] sample_ext_t;

  // saturation limits
  localparam sample_t sample_max = {1'b0, {(adc_dw-1){1'b1}}};
  localparam sample_t sample_min = {1'b1, {(adc_dw-1){1'b0}}};

  // trigger edge source
  typedef enum logic [2:0] {
    trg_none    = 3'd0,
    trg_ch0_pos = 3'd1,
    trg_ch0_neg = 3'd2,
    trg_ch1_pos = 3'd3,
    trg_ch1_neg = 3'd4
  } trig_src_t;

  // trigger controller states
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_armed = 2'd1,
    st_post  = 2'd2
  } acq_state_t;

endpackage : scope_pkg

`default_nettype wire

// File: hw/scope_top.sv
/*
  dual-channel scope acquisition front end
  two calibrated ADC channels feeding one armable trigger controller
*/
`default_nettype none

module scope_top (
  input  wire logic                         adc_clk,
  input  wire logic                         top_rst,
  // converter pins
  input  wire scope_pkg::raw_t              adc_dat0_i,
  input  wire scope_pkg::raw_t              adc_dat1_i,
  // per channel calibration and comparator
  input  wire scope_pkg::sample_t           ch0_offset_i,
  input  wire scope_pkg::sample_t           ch1_offset_i,
  input  wire scope_pkg::sample_t           ch0_level_i,
  input  wire scope_pkg::sample_t           ch1_level_i,
  input  wire scope_pkg::sample_t           ch0_hyst_i,
  input  wire scope_pkg::sample_t           ch1_hyst_i,
  // trigger control
  input  wire scope_pkg::trig_src_t         trig_src_i,
  input  wire logic                         arm_i,
  input  wire logic [scope_pkg::cnt_dw-1:0] post_cnt_i,
  // sample streams, 2 cycles behind the pins
  output scope_pkg::sample_t                ch0_dat_o,
  output scope_pkg::sample_t                ch1_dat_o,
  // trigger status and snapshot
  output logic                              trig_o,
  output scope_pkg::sample_t                trig_dat0_o,
  output scope_pkg::sample_t                trig_dat1_o,
  output logic                              busy_o,
  output logic                              done_o
);

  // channel buses
  adc_chan_if ch0_bus ();
  adc_chan_if ch1_bus ();

  ////////////////////////////////////////
  // channels
  ////////////////////////////////////////

  adc_channel chan0 (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .raw_i    (adc_dat0_i),
    .offset_i (ch0_offset_i),
    .level_i  (ch0_level_i),
    .hyst_i   (ch0_hyst_i),
    .chan     (ch0_bus)
  );

  adc_channel chan1 (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .raw_i    (adc_dat1_i),
    .offset_i (ch1_offset_i),
    .level_i  (ch1_level_i),
    .hyst_i   (ch1_hyst_i),
    .chan     (ch1_bus)
  );

  // calibrated samples straight out
  assign ch0_dat_o = ch0_bus.sample;
  assign ch1_dat_o = ch1_bus.sample;

  ////////////////////////////////////////
  // trigger
  ////////////////////////////////////////

  acq_trigger trigger (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .ch0         (ch0_bus),
    .ch1         (ch1_bus),
    .trig_src_i  (trig_src_i),
    .arm_i       (arm_i),
    .post_cnt_i  (post_cnt_i),
    .trig_o      (trig_o),
    .trig_dat0_o (trig_dat0_o),
    .trig_dat1_o (trig_dat1_o),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

endmodule : scope_top

`default_nettype wire

// File: scope_top.f
hw/scope_pkg.sv
hw/adc_chan_if.sv
hw/adc_channel.sv
hw/acq_trigger.sv
hw/scope_top.sv
verification/tb_clock.sv
verification/tb_scope_top.sv

// File: verification/tb_clock.sv
/*
  testbench clock and reset
  20 ns adc_clk, top_rst held for the first 5 rising edges
*/
`default_nettype none

module tb_clock (
  output logic adc_clk,
  output logic top_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  // release a little after the edge, like the other inputs
  initial begin
    top_rst = 1'b1;
    repeat (5) @(posedge adc_clk);
    #2 top_rst = 1'b0;
  end

endmodule : tb_clock

`default_nettype wire

// File: verification/tb_scope_top.sv
/*
  testbench for the dual-channel scope front end
  LFSR and ramp stimulus, a cycle model of both channels and the trigger,
  concurrent checks of the DUT against that model
*/
`default_nettype none

module tb_scope_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic adc_clk;
  logic top_rst;
  scope_pkg::raw_t raw0, raw1;
  scope_pkg::sample_t off0, off1, lvl0, lvl1, hys0, hys1;
  scope_pkg::trig_src_t src;
  logic arm;
  logic [scope_pkg::cnt_dw-1:0] post_cnt;
  scope_pkg::sample_t ch0_dat, ch1_dat, tdat0, tdat1;
  logic trig, busy, done;

  int errors, err_mark, tests_ok, tests_bad;
  logic [15:0] lfsr;
  logic rst_d1;

  // model state
  scope_pkg::raw_t m_raw0, m_raw1;
  scope_pkg::sample_t m_s0, m_s1, m_snap0, m_snap1;
  logic m_ab0, m_ab1, m_pos0, m_neg0, m_pos1, m_neg1;
  logic m_trig, m_done, m_armed, m_post;
  scope_pkg::trig_src_t m_src;
  int m_left;

  tb_clock clk_gen (.adc_clk(adc_clk), .top_rst(top_rst));

  scope_top dut (
    .adc_clk(adc_clk), .top_rst(top_rst),
    .adc_dat0_i(raw0), .adc_dat1_i(raw1),
    .ch0_offset_i(off0), .ch1_offset_i(off1),
    .ch0_level_i(lvl0), .ch1_level_i(lvl1),
    .ch0_hyst_i(hys0), .ch1_hyst_i(hys1),
    .trig_src_i(src), .arm_i(arm), .post_cnt_i(post_cnt),
    .ch0_dat_o(ch0_dat), .ch1_dat_o(ch1_dat),
    .trig_o(trig), .trig_dat0_o(tdat0), .trig_dat1_o(tdat1),
    .busy_o(busy), .done_o(done)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[14:0], fb};
    end
    return r;
  endfunction

  // sign kept, low bits inverted, offset added and clamped in int range
  function automatic scope_pkg::sample_t calib(input scope_pkg::raw_t raw,
                                               input scope_pkg::sample_t off);
    int v;
    v = int'(scope_pkg::sample_t'(raw ^ 16'h7fff)) + int'(off);
    if (v > int'(scope_pkg::sample_max)) v = int'(scope_pkg::sample_max);
    if (v < int'(scope_pkg::sample_min)) v = int'(scope_pkg::sample_min);
    return scope_pkg::sample_t'(v);
  endfunction

  function automatic logic cmp(input scope_pkg::sample_t s, input scope_pkg::sample_t lvl,
                               input scope_pkg::sample_t hys, input logic cur);
    if (int'(s) > int'(lvl) + int'(hys)) return 1'b1;
    if (int'(s) < int'(lvl) - int'(hys)) return 1'b0;
    return cur;
  endfunction

  // raw word that reads back as v with a zero offset
  function automatic scope_pkg::raw_t raw_of(input int v);
    return scope_pkg::raw_t'(v) ^ 16'h7fff;
  endfunction

  // 2-deep raw history, first stage here
  always @(posedge adc_clk) begin
    m_raw0 <= raw0;
    m_raw1 <= raw1;
    rst_d1 <= top_rst;
  end

  always @(posedge adc_clk or posedge top_rst) begin : model
    logic a0, a1, hit;
    if (top_rst) begin
      {m_s0, m_s1, m_snap0, m_snap1} <= '0;
      {m_ab0, m_ab1, m_pos0, m_neg0, m_pos1, m_neg1} <= '0;
      {m_trig, m_done, m_armed, m_post} <= '0;
      m_src  <= scope_pkg::trg_none;
      m_left <= 0;
    end else begin
      a0 = cmp(m_s0, lvl0, hys0, m_ab0);
      a1 = cmp(m_s1, lvl1, hys1, m_ab1);
      m_s0   <= calib(m_raw0, off0);
      m_s1   <= calib(m_raw1, off1);
      m_ab0  <= a0;
      m_ab1  <= a1;
      m_pos0 <= a0 && !m_ab0;
      m_neg0 <= !a0 && m_ab0;
      m_pos1 <= a1 && !m_ab1;
      m_neg1 <= !a1 && m_ab1;
      // trigger controller
      hit = (m_src == scope_pkg::trg_ch0_pos && m_pos0) ||
            (m_src == scope_pkg::trg_ch0_neg && m_neg0) ||
            (m_src == scope_pkg::trg_ch1_pos && m_pos1) ||
            (m_src == scope_pkg::trg_ch1_neg && m_neg1);
      m_trig <= 1'b0;
      m_done <= 1'b0;
      if (!m_armed && !m_post && arm) begin
        m_armed <= 1'b1;
        m_src   <= src;
      end
      if (m_armed && hit) begin
        m_armed <= 1'b0;
        m_post  <= 1'b1;
        m_trig  <= 1'b1;
        m_snap0 <= m_s0;
        m_snap1 <= m_s1;
        // zero window still ends one cycle after the trigger
        m_left  <= (post_cnt == '0) ? 1 : int'(post_cnt);
      end
      if (m_post) begin
        if (m_left <= 1) begin
          m_post <= 1'b0;
          m_done <= 1'b1;
        end else begin
          m_left <= m_left - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_reset: assert property (@(posedge adc_clk) (top_rst || rst_d1) |->
    (!trig && !done && !busy && ch0_dat == '0 && ch1_dat == '0 && tdat0 == '0 && tdat1 == '0))
    else begin
      errors++;
      $display("Mismatch at %0t: outputs not cleared around reset", $time);
    end

  a_dat: assert property (@(posedge adc_clk) disable iff (top_rst)
    ch0_dat == m_s0 && ch1_dat == m_s1)
    else begin
      errors++;
      $display("Mismatch at %0t: samples %0d %0d, expected %0d %0d", $time,
               $sampled(ch0_dat), $sampled(ch1_dat), $sampled(m_s0), $sampled(m_s1));
    end

  a_cmp: assert property (@(posedge adc_clk) disable iff (top_rst)
    dut.ch0_bus.above == m_ab0 && dut.ch0_bus.pos_edge == m_pos0 &&
    dut.ch0_bus.neg_edge == m_neg0 && dut.ch1_bus.above == m_ab1 &&
    dut.ch1_bus.pos_edge == m_pos1 && dut.ch1_bus.neg_edge == m_neg1)
    else begin
      errors++;
      $display("Mismatch at %0t: comparator level or edge pulse wrong", $time);
    end

  a_ctrl: assert property (@(posedge adc_clk) disable iff (top_rst)
    trig == m_trig && done == m_done && busy == (m_armed || m_post))
    else begin
      errors++;
      $display("Mismatch at %0t: trig %b done %b busy %b, expected %b %b %b", $time,
               $sampled(trig), $sampled(done), $sampled(busy),
               $sampled(m_trig), $sampled(m_done), $sampled(m_armed || m_post));
    end

  a_snap: assert property (@(posedge adc_clk) disable iff (top_rst)
    tdat0 == m_snap0 && tdat1 == m_snap1)
    else begin
      errors++;
      $display("Mismatch at %0t: snapshot %0d %0d, expected %0d %0d", $time,
               $sampled(tdat0), $sampled(tdat1), $sampled(m_snap0), $sampled(m_snap1));
    end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // inputs change 2 ns after the edge
  task automatic tick;
    @(posedge adc_clk);
    #2;
  endtask

  task automatic set_chan(input int ch, input int v);
    if (ch == 0) raw0 = raw_of(v);
    else raw1 = raw_of(v);
  endtask

  task automatic hold(input int ch, input int v, input int cycles);
    set_chan(ch, v);
    repeat (cycles) tick;
  endtask

  task automatic ramp(input int ch, input int from, input int to);
    int i;
    for (i = 0; i <= 20; i++) begin
      set_chan(ch, from + ((to - from) * i) / 20);
      tick;
    end
  endtask

  // stays strictly inside the +-100 band
  task automatic wobble(input int ch);
    int i;
    for (i = 0; i < 12; i++) begin
      set_chan(ch, (i % 2 == 0) ? (95 - 7 * i) : -(95 - 7 * i));
      tick;
    end
  endtask

  task automatic run_random(input int cycles);
    repeat (cycles) begin
      raw0 = rand_bits(16);
      raw1 = rand_bits(16);
      tick;
    end
  endtask

  task automatic wait_reset;
    int n;
    n = 0;
    while (top_rst && n < 20) begin
      @(negedge adc_clk);
      n++;
    end
    if (top_rst) begin
      errors++;
      $display("reset was never released");
    end
    tick;
  endtask

  // source channel keeps moving away from the band, every cycle a new sample
  task automatic wait_trig(input int ch, input int v, input int limit);
    int n;
    n = 0;
    while (!trig && n < limit) begin
      tick;
      n++;
      set_chan(ch, (v > 0) ? v + 10 * n : v - 10 * n);
    end
    if (!trig) begin
      errors++;
      $display("timeout: no trigger within %0d cycles", limit);
    end
  endtask

  // arm is already high for the first cycle, busy is set then
  task automatic wait_done(input int limit, input int expect_n);
    int n;
    n = 0;
    do begin
      tick;
      arm = 1'b0;
      n++;
    end while (!done && n < limit);
    if (!done) begin
      errors++;
      $display("timeout: no done pulse within %0d cycles", limit);
    end else begin
      assert (n == expect_n) else begin
        errors++;
        $display("Mismatch at %0t: done after %0d cycles, expected %0d", $time, n, expect_n);
      end
    end
  endtask

  // wrong polarity first, other channel toggles, then the real crossing
  task automatic cross_test(input scope_pkg::trig_src_t s, input int post);
    int ch, start;
    ch = (s == scope_pkg::trg_ch1_pos || s == scope_pkg::trg_ch1_neg) ? 1 : 0;
    start = (s == scope_pkg::trg_ch0_pos || s == scope_pkg::trg_ch1_pos) ? 500 : -500;
    hold(ch, start, 6);
    src = s;
    post_cnt = post[scope_pkg::cnt_dw-1:0];
    arm = 1'b1;
    tick;
    arm = 1'b0;
    // source only matters at arm
    src = scope_pkg::trg_none;
    ramp(ch, start, -start);
    wobble(ch);
    hold(1 - ch, 500, 5);
    hold(1 - ch, -500, 5);
    ramp(ch, -start, (start * 9) / 50);
    set_chan(ch, start);
    wait_trig(ch, start, 20);
    arm = 1'b1;
    wait_done(post + 20, (post == 0) ? 1 : post);
    hold(ch, start, 4);
  endtask

  task automatic start_test;
    err_mark = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  function automatic scope_pkg::sample_t small_off;
    logic [15:0] r;
    r = rand_bits(8);
    return scope_pkg::sample_t'({{8{r[7]}}, r[7:0]});
  endfunction

  initial begin
    // 7fff reads back as zero, keeps outputs at reset value
    raw0 = 16'h7fff;
    raw1 = 16'h7fff;
    {off0, off1, lvl0, lvl1} = '0;
    hys0 = 16'sd100;
    hys1 = 16'sd100;
    src = scope_pkg::trg_none;
    arm = 1'b0;
    post_cnt = '0;
    {errors, err_mark, tests_ok, tests_bad} = '0;
    lfsr = 16'd95;

    start_test;
    wait_reset;
    repeat (3) tick;
    finish_test("reset");

    // distinct band per channel while the data is random
    start_test;
    lvl0 = 16'sh2000;
    lvl1 = -16'sh3000;
    hys0 = 16'sd1500;
    hys1 = 16'sd300;
    repeat (4) begin
      off0 = small_off();
      off1 = small_off();
      run_random(50);
    end
    finish_test("conversion");

    // 0x9000 is -28672
    start_test;
    off0 = 16'sh7000;
    off1 = 16'sh9000;
    run_random(100);
    off0 = 16'sh9000;
    off1 = 16'sh7000;
    run_random(100);
    finish_test("saturation");

    off0 = '0;
    off1 = '0;
    lvl0 = '0;
    lvl1 = '0;
    hys0 = 16'sd100;
    hys1 = 16'sd100;
    hold(0, -500, 2);
    hold(1, -500, 6);

    start_test;
    cross_test(scope_pkg::trg_ch0_pos, 0);
    finish_test("ch0 rising, window 0");
    start_test;
    cross_test(scope_pkg::trg_ch0_neg, 1);
    finish_test("ch0 falling, window 1");
    start_test;
    cross_test(scope_pkg::trg_ch1_pos, 5);
    finish_test("ch1 rising, window 5");
    start_test;
    cross_test(scope_pkg::trg_ch1_neg, 12);
    finish_test("ch1 falling, window 12");

    // no source, stays armed through every kind of edge
    start_test;
    src = scope_pkg::trg_none;
    arm = 1'b1;
    tick;
    arm = 1'b0;
    hold(0, 500, 6);
    hold(1, 500, 6);
    hold(0, -500, 6);
    hold(1, -500, 6);
    assert (busy) else begin
      errors++;
      $display("controller left the armed state without a trigger source");
    end
    finish_test("no trigger source");

    $display("tests passed %0d failed %0d, check errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // overall limit on the run
  initial begin
    #200000;
    $display("simulation did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule : tb_scope_top

`default_nettype wire
